/* tests/bridge_trace.txt */
// Columns in hex: op addr data strb aux expect
// op 1 wr, 2 rd, 3 rd with aux stall cycles, 4 byte wr, 5 byte rd, 6 wr plus rd at aux, 0 end
// Full word writes and read back
1 00 11223344 f 0 00000000
2 00 00000000 0 0 11223344
1 04 deadbeef f 0 00000000
2 04 00000000 0 0 deadbeef
1 fc a5a55a5a f 0 00000000
2 fc 00000000 0 0 a5a55a5a
// Partial strobes merge into the old word
1 08 01020304 f 0 00000000
1 08 aabbccdd 5 0 00000000
2 08 00000000 0 0 01bb03dd
1 08 ffeeddcc 8 0 00000000
2 08 00000000 0 0 ffbb03dd
1 0c 00000000 f 0 00000000
1 0c 12345678 6 0 00000000
2 0c 00000000 0 0 00345600
// Byte writes seen in their word lanes
1 10 00000000 f 0 00000000
4 12 0000007e 1 0 00000000
2 10 00000000 0 0 007e0000
4 13 000000c3 1 0 00000000
2 10 00000000 0 0 c37e0000
4 11 00000001 1 0 00000000
4 10 00000099 1 0 00000000
2 10 00000000 0 0 c37e0199
// Word split into little-endian bytes
1 20 8badf00d f 0 00000000
5 20 00000000 0 0 0000000d
5 21 00000000 0 0 000000f0
5 22 00000000 0 0 000000ad
5 23 00000000 0 0 0000008b
5 12 00000000 0 0 0000007e
// Write and read offered together
6 30 cafef00d f 04 deadbeef
2 30 00000000 0 0 cafef00d
6 34 13579bdf f 30 cafef00d
2 34 00000000 0 0 13579bdf
// Reads held by rready
3 00 00000000 0 5 11223344
3 08 00000000 0 3 ffbb03dd
3 20 00000000 0 a 8badf00d
0 00 00000000 0 0 00000000

/* project.f */
hdl/axil_bram_pkg.sv
hdl/mem_port_if.sv
hdl/axil_ram_port.sv
hdl/byte_ram_port.sv
hdl/dual_width_bram.sv
hdl/axil_bram_bridge.sv
tests/tb_axil_bram_bridge.sv

/* Makefile */
TOP := tb_axil_bram_bridge

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only --timing -f project.f --top-module axil_bram_bridge

clean:
	rm -rf obj_dir sim.log

/* tests/tb_axil_bram_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axil_bram_bridge;

  import axil_bram_pkg::*;

  localparam int PIPE_OUT    = 0;
  localparam int CLK_HALF    = 4;   // 8 ns period
  localparam int DRIVE_DLY   = 1;   // Inputs change this long after the rising edge
  localparam int TIMEOUT_CYC = 50;
  localparam int FIELDS      = 6;   // op, addr, data, strb, aux, expect
  localparam int MAX_OPS     = 64;

  typedef enum int {SEL_AWREADY, SEL_BVALID, SEL_ARREADY, SEL_RVALID, SEL_DACK} sig_sel_t;

  logic                     clka;
  logic                     rsta;
  logic [AXIL_ADDR_W-1:0]   awaddr;
  logic [2:0]               awprot;
  logic                     awvalid;
  logic                     awready;
  logic [AXIL_DATA_W-1:0]   wdata;
  logic [AXIL_DATA_W/8-1:0] wstrb;
  logic                     wvalid;
  logic                     wready;
  axil_resp_t               bresp;
  logic                     bvalid;
  logic                     bready;
  logic [AXIL_ADDR_W-1:0]   araddr;
  logic [2:0]               arprot;
  logic                     arvalid;
  logic                     arready;
  logic [AXIL_DATA_W-1:0]   rdata;
  axil_resp_t               rresp;
  logic                     rvalid;
  logic                     rready;
  logic                     rden;
  logic                     wren;
  logic [BRAM_DATA_W/8-1:0] wrstrb;
  logic [AXIL_ADDR_W-1:0]   addr;
  logic [BRAM_DATA_W-1:0]   din;
  logic [BRAM_DATA_W-1:0]   dout;
  logic                     dack;

  logic [31:0] trace_mem [FIELDS*MAX_OPS];
  logic [31:0] op, t_addr, t_data, t_strb, t_aux, t_exp;
  string       step_name;
  int          ops_run;

  axil_bram_bridge #(.PIPELINE_OUTPUT(PIPE_OUT)) dut_i (.*);

  initial begin
    clka = 1'b0;
    forever #CLK_HALF clka = ~clka;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Error handling and compares
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [AXIL_DATA_W-1:0] expected,
                            input logic [AXIL_DATA_W-1:0] actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_byte(input string name, input logic [BRAM_DATA_W-1:0] expected,
                            input logic [BRAM_DATA_W-1:0] actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_t expected,
                            input axil_resp_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("Fail %s: expected %s, actual %b", name, expected.name(),
                              actual));
    end
  endtask

  function automatic logic signal_level(input sig_sel_t sel);
    case (sel)
      SEL_AWREADY: return awready;
      SEL_BVALID:  return bvalid;
      SEL_ARREADY: return arready;
      SEL_RVALID:  return rvalid;
      default:     return dack;
    endcase
  endfunction

  // Samples at falling edges, counts the edges passed before the flag was seen
  task automatic wait_for_high(input sig_sel_t sel, output int cycles);
    cycles = 0;
    @(negedge clka);
    while (!signal_level(sel)) begin
      cycles++;
      if (cycles > TIMEOUT_CYC) begin
        stop_on_error($sformatf("Timeout while waiting for %s", sel.name()));
      end
      @(negedge clka);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus drivers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic axi_write(input string name, input logic [AXIL_ADDR_W-1:0] a,
                           input logic [AXIL_DATA_W-1:0] d,
                           input logic [AXIL_DATA_W/8-1:0] s);
    int cycles;
    @(posedge clka);
    #DRIVE_DLY;
    awaddr  = a;
    wdata   = d;
    wstrb   = s;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    wait_for_high(SEL_AWREADY, cycles);
    if (!wready) stop_on_error("wready did not pulse together with awready");
    if (!bvalid) stop_on_error("bvalid did not rise in the write accept cycle");
    check_resp({name, " bresp"}, RESP_OKAY, bresp);
    @(posedge clka);
    #DRIVE_DLY;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    wait_for_high(SEL_BVALID, cycles);  // Still held, bready was low
    @(posedge clka);
    #DRIVE_DLY;
    bready = 1'b0;
  endtask

  task automatic axi_read(input string name, input logic [AXIL_ADDR_W-1:0] a,
                          input int stall, input logic [AXIL_DATA_W-1:0] expected);
    int cycles;
    @(posedge clka);
    #DRIVE_DLY;
    araddr  = a;
    arvalid = 1'b1;
    wait_for_high(SEL_ARREADY, cycles);
    if (PIPE_OUT == 0 && !rvalid) stop_on_error("rvalid did not rise with arready");
    @(posedge clka);
    #DRIVE_DLY;
    arvalid = 1'b0;
    wait_for_high(SEL_RVALID, cycles);
    check_word(name, expected, rdata);
    check_resp({name, " rresp"}, RESP_OKAY, rresp);
    for (int i = 0; i < stall; i++) begin
      @(negedge clka);
      if (!rvalid) stop_on_error("rvalid dropped while rready was low");
      check_word($sformatf("%s stall %0d", name, i), expected, rdata);
    end
    @(posedge clka);
    #DRIVE_DLY;
    rready = 1'b1;
    @(posedge clka);
    #DRIVE_DLY;
    rready = 1'b0;
  endtask

  // Write and read offered in the same cycle, each valid dropped after its ready
  task automatic axi_write_read(input string name, input logic [AXIL_ADDR_W-1:0] wa,
                                input logic [AXIL_DATA_W-1:0] wd,
                                input logic [AXIL_DATA_W/8-1:0] ws,
                                input logic [AXIL_ADDR_W-1:0] ra,
                                input logic [AXIL_DATA_W-1:0] expected);
    logic aw_done;
    logic ar_done;
    logic aw_hit;
    logic ar_hit;
    int   cycles;
    int   n;
    @(posedge clka);
    #DRIVE_DLY;
    awaddr  = wa;
    wdata   = wd;
    wstrb   = ws;
    araddr  = ra;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    arvalid = 1'b1;
    aw_done = 1'b0;
    ar_done = 1'b0;
    n       = 0;
    while (!(aw_done && ar_done)) begin
      @(negedge clka);
      aw_hit = awready;
      ar_hit = arready;
      n++;
      if (n > TIMEOUT_CYC) stop_on_error("Timeout while the paired write and read waited");
      @(posedge clka);
      #DRIVE_DLY;
      if (aw_hit) begin
        awvalid = 1'b0;
        wvalid  = 1'b0;
        aw_done = 1'b1;
      end
      if (ar_hit) begin
        arvalid = 1'b0;
        ar_done = 1'b1;
      end
    end
    wait_for_high(SEL_BVALID, cycles);
    wait_for_high(SEL_RVALID, cycles);
    check_word(name, expected, rdata);
    check_resp({name, " bresp"}, RESP_OKAY, bresp);
    check_resp({name, " rresp"}, RESP_OKAY, rresp);
    @(posedge clka);
    #DRIVE_DLY;
    bready = 1'b1;
    rready = 1'b1;
    @(posedge clka);
    #DRIVE_DLY;
    bready = 1'b0;
    rready = 1'b0;
  endtask

  task automatic byte_access(input string name, input logic is_write,
                             input logic [AXIL_ADDR_W-1:0] a,
                             input logic [BRAM_DATA_W-1:0] d,
                             input logic [BRAM_DATA_W-1:0] expected);
    int cycles;
    @(posedge clka);
    #DRIVE_DLY;
    addr   = a;
    din    = d;
    wrstrb = '1;
    wren   = is_write;
    rden   = !is_write;
    @(negedge clka);
    if (dack) stop_on_error("dack was high in the cycle of the enable");
    @(posedge clka);
    #DRIVE_DLY;
    wren = 1'b0;
    rden = 1'b0;
    wait_for_high(SEL_DACK, cycles);
    if (cycles != 0) stop_on_error($sformatf("%s: dack came %0d cycles late", name, cycles));
    if (!is_write) begin
      check_byte(name, expected, dout);
      @(negedge clka);
      if (dack) stop_on_error("dack stayed high for more than one cycle");
      check_byte({name, " held"}, expected, dout);  // dout kept after dack
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Trace player
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    rsta    = 1'b1;
    awaddr  = '0;
    awprot  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arprot  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    rden    = 1'b0;
    wren    = 1'b0;
    wrstrb  = '0;
    addr    = '0;
    din     = '0;
    ops_run = 0;
    for (int i = 0; i < FIELDS*MAX_OPS; i++) begin
      trace_mem[i] = '0;  // Missing lines read as the end code
    end
    $readmemh("tests/bridge_trace.txt", trace_mem);

    repeat (4) @(posedge clka);
    #DRIVE_DLY;
    rsta = 1'b0;
    @(negedge clka);
    if (awready || wready || arready || bvalid || rvalid || dack) begin
      stop_on_error("Handshake outputs were not low after reset");
    end

    for (int i = 0; i < MAX_OPS; i++) begin
      op     = trace_mem[i*FIELDS];
      t_addr = trace_mem[i*FIELDS + 1];
      t_data = trace_mem[i*FIELDS + 2];
      t_strb = trace_mem[i*FIELDS + 3];
      t_aux  = trace_mem[i*FIELDS + 4];
      t_exp  = trace_mem[i*FIELDS + 5];
      if (op == 0) break;
      step_name = $sformatf("step %0d op %0d addr %h", i, op, t_addr[7:0]);
      case (op)
        1: axi_write(step_name, t_addr[7:0], t_data, t_strb[3:0]);
        2: axi_read(step_name, t_addr[7:0], 0, t_exp);
        3: axi_read(step_name, t_addr[7:0], int'(t_aux), t_exp);
        4: byte_access(step_name, 1'b1, t_addr[7:0], t_data[7:0], '0);
        5: byte_access(step_name, 1'b0, t_addr[7:0], '0, t_exp[7:0]);
        6: axi_write_read(step_name, t_addr[7:0], t_data, t_strb[3:0], t_aux[7:0], t_exp);
        default: stop_on_error($sformatf("Unknown operation code %0d in the trace", op));
      endcase
      ops_run++;
    end

    @(posedge clka);
    if (ops_run == 0) begin
      stop_on_error("No operations were read from the trace file");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* hdl/axil_bram_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_bram_bridge #(
  parameter int ADDR_W          = axil_bram_pkg::AXIL_ADDR_W,
  parameter int A_DATA_W        = axil_bram_pkg::AXIL_DATA_W,
  parameter int B_DATA_W        = axil_bram_pkg::BRAM_DATA_W,
  parameter int PIPELINE_OUTPUT = 0,
  localparam int A_STRB_W       = A_DATA_W / 8,
  localparam int B_STRB_W       = B_DATA_W / 8,
  localparam int WORD_ADDR_W    = ADDR_W - $clog2(A_STRB_W),
  localparam int B_ADDR_W       = ADDR_W - $clog2(B_STRB_W)
) (
  input  logic                      clka,
  input  logic                      rsta,

  // AXI-Lite port A
  input  logic [ADDR_W-1:0]         awaddr,
  input  logic [2:0]                awprot,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [A_DATA_W-1:0]       wdata,
  input  logic [A_STRB_W-1:0]       wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output axil_bram_pkg::axil_resp_t bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic [ADDR_W-1:0]         araddr,
  input  logic [2:0]                arprot,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [A_DATA_W-1:0]       rdata,
  output axil_bram_pkg::axil_resp_t rresp,
  output logic                      rvalid,
  input  logic                      rready,

  // Native byte port B
  input  logic                      rden,
  input  logic                      wren,
  input  logic [B_STRB_W-1:0]       wrstrb,
  input  logic [B_ADDR_W-1:0]       addr,
  input  logic [B_DATA_W-1:0]       din,
  output logic [B_DATA_W-1:0]       dout,
  output logic                      dack
);

  mem_port_if #(.ADDR_W(WORD_ADDR_W), .DATA_W(A_DATA_W), .STRB_W(A_STRB_W)) mem_a ();
  mem_port_if #(.ADDR_W(B_ADDR_W), .DATA_W(B_DATA_W), .STRB_W(B_STRB_W)) mem_b ();

  axil_ram_port #(
    .ADDR_W          (ADDR_W),
    .A_DATA_W        (A_DATA_W),
    .PIPELINE_OUTPUT (PIPELINE_OUTPUT)
  ) axil_port_i (
    .clka    (clka),
    .rsta    (rsta),
    .awaddr  (awaddr),
    .awprot  (awprot),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arprot  (arprot),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .mem     (mem_a.ctrl)
  );

  byte_ram_port #(
    .ADDR_W   (ADDR_W),
    .B_DATA_W (B_DATA_W)
  ) byte_port_i (
    .clka   (clka),
    .rsta   (rsta),
    .rden   (rden),
    .wren   (wren),
    .wrstrb (wrstrb),
    .addr   (addr),
    .din    (din),
    .dout   (dout),
    .dack   (dack),
    .mem    (mem_b.ctrl)
  );

  dual_width_bram #(
    .ADDR_W   (ADDR_W),
    .A_DATA_W (A_DATA_W),
    .B_DATA_W (B_DATA_W)
  ) bram_i (
    .clka (clka),
    .a    (mem_a.mem),
    .b    (mem_b.mem)
  );

endmodule

`default_nettype wire

/* hdl/dual_width_bram.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_width_bram #(
  parameter int ADDR_W   = axil_bram_pkg::AXIL_ADDR_W,
  parameter int A_DATA_W = axil_bram_pkg::AXIL_DATA_W,
  parameter int B_DATA_W = axil_bram_pkg::BRAM_DATA_W
) (
  input  logic    clka,
  mem_port_if.mem a,
  mem_port_if.mem b
);

  import axil_bram_pkg::*;

  localparam int A_STRB_W    = A_DATA_W / 8;
  localparam int B_STRB_W    = B_DATA_W / 8;
  localparam int WORD_ADDR_W = ADDR_W - $clog2(A_STRB_W);
  localparam int DEPTH       = 1 << WORD_ADDR_W;
  localparam int B_LANES     = A_DATA_W / B_DATA_W;   // Port B slices per word
  localparam int B_LANE_BITS = $clog2(B_LANES);
  localparam int B_LANE_W    = (B_LANE_BITS > 0) ? B_LANE_BITS : 1;

  logic [A_DATA_W-1:0]    ram [DEPTH];
  logic [WORD_ADDR_W-1:0] b_word;
  logic [B_LANE_W-1:0]    b_lane;
  logic [B_STRB_W-1:0]    a_strb_at_b;  // Port A enables over port B's slice

  // Little-endian split of the port B address
  assign b_word = WORD_ADDR_W'(word_index(32'(b.addr), B_LANE_BITS));
  assign b_lane = B_LANE_W'(byte_lane(32'(b.addr), B_LANE_BITS));

  assign a_strb_at_b = a.strb[b_lane*B_STRB_W +: B_STRB_W];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Writes from both ports
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clka) begin
    for (int i = 0; i < A_STRB_W; i++) begin
      if (a.en_wr && a.strb[i]) begin
        ram[a.addr][i*8 +: 8] <= a.wdata[i*8 +: 8];
      end
    end
    for (int j = 0; j < B_STRB_W; j++) begin
      if (b.en_wr && b.strb[j]) begin
        ram[b_word][(b_lane*B_STRB_W + j)*8 +: 8] <= b.wdata[j*8 +: 8];  // One lane
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Synchronous reads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clka) begin
    if (a.en_rd) begin
      a.rdata <= ram[a.addr];
    end
  end

  always_ff @(posedge clka) begin
    if (b.en_rd) begin
      b.rdata <= ram[b_word][b_lane*B_DATA_W +: B_DATA_W];  // Lane select
    end
  end

  // Byte collision between the two writers
  a_no_write_clash : assert property (@(posedge clka)
    !(a.en_wr && b.en_wr && (a.addr == b_word) && |(a_strb_at_b & b.strb)))
    else $error("Both ports wrote the same byte");

endmodule

`default_nettype wire

/* hdl/byte_ram_port.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_ram_port #(
  parameter int ADDR_W   = axil_bram_pkg::AXIL_ADDR_W,
  parameter int B_DATA_W = axil_bram_pkg::BRAM_DATA_W,
  localparam int B_STRB_W = B_DATA_W / 8,
  localparam int B_ADDR_W = ADDR_W - $clog2(B_STRB_W)
) (
  input  logic                clka,
  input  logic                rsta,

  input  logic                rden,
  input  logic                wren,
  input  logic [B_STRB_W-1:0] wrstrb,
  input  logic [B_ADDR_W-1:0] addr,
  input  logic [B_DATA_W-1:0] din,
  output logic [B_DATA_W-1:0] dout,
  output logic                dack,

  mem_port_if.ctrl            mem
);

  logic                rd_q;       // Read data arrives this cycle
  logic                dack_q;
  logic [B_DATA_W-1:0] dout_hold_q;

  // Request side goes straight to the storage
  assign mem.en_rd = rden;
  assign mem.en_wr = wren;
  assign mem.strb  = wrstrb;
  assign mem.addr  = addr;
  assign mem.wdata = din;

  always_ff @(posedge clka) begin
    if (rsta) begin
      rd_q   <= 1'b0;
      dack_q <= 1'b0;
    end else begin
      rd_q   <= rden;
      dack_q <= rden || wren;  // One pulse per access
    end
  end

  always_ff @(posedge clka) begin
    if (rd_q) begin
      dout_hold_q <= mem.rdata;  // Kept until the next read
    end
  end

  assign dack = dack_q;
  assign dout = rd_q ? mem.rdata : dout_hold_q;

  // One access type per cycle on the client side
  a_single_op : assert property (@(posedge clka) disable iff (rsta)
    !(rden && wren))
    else $error("rden and wren asserted together");

endmodule

`default_nettype wire

/* hdl/axil_ram_port.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_ram_port #(
  parameter int ADDR_W          = axil_bram_pkg::AXIL_ADDR_W,
  parameter int A_DATA_W        = axil_bram_pkg::AXIL_DATA_W,
  parameter int PIPELINE_OUTPUT = 0,
  localparam int STRB_W         = A_DATA_W / 8
) (
  input  logic                      clka,
  input  logic                      rsta,

  input  logic [ADDR_W-1:0]         awaddr,
  input  logic [2:0]                awprot,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [A_DATA_W-1:0]       wdata,
  input  logic [STRB_W-1:0]         wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output axil_bram_pkg::axil_resp_t bresp,
  output logic                      bvalid,
  input  logic                      bready,

  input  logic [ADDR_W-1:0]         araddr,
  input  logic [2:0]                arprot,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [A_DATA_W-1:0]       rdata,
  output axil_bram_pkg::axil_resp_t rresp,
  output logic                      rvalid,
  input  logic                      rready,

  mem_port_if.ctrl                  mem
);

  import axil_bram_pkg::*;

  localparam int LANE_BITS   = $clog2(STRB_W);
  localparam int WORD_ADDR_W = ADDR_W - LANE_BITS;
  localparam bit PIPE        = (PIPELINE_OUTPUT != 0);

  logic                   write_eligible;
  logic                   read_eligible;
  logic                   mem_wr;
  logic                   mem_rd;
  logic                   last_read_q, last_read_d;  // Last grant went to a read
  logic                   awready_q, awready_d;
  logic                   wready_q, wready_d;
  logic                   bvalid_q, bvalid_d;
  logic                   arready_q, arready_d;
  logic                   rvalid_q, rvalid_d;
  logic                   rvalid_pipe_q;
  logic                   rd_en_q;                   // Memory data lands this cycle
  logic [A_DATA_W-1:0]    rdata_hold_q;
  logic [A_DATA_W-1:0]    rdata_core;
  logic [A_DATA_W-1:0]    rdata_pipe_q;
  logic [WORD_ADDR_W-1:0] aw_word;
  logic [WORD_ADDR_W-1:0] ar_word;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Channel outputs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign awready = awready_q;
  assign wready  = wready_q;
  assign bvalid  = bvalid_q;
  assign bresp   = RESP_OKAY;
  assign arready = arready_q;
  assign rvalid  = PIPE ? rvalid_pipe_q : rvalid_q;
  assign rdata   = PIPE ? rdata_pipe_q : rdata_core;
  assign rresp   = RESP_OKAY;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Arbitration between write and read
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    mem_wr      = 1'b0;
    mem_rd      = 1'b0;
    last_read_d = last_read_q;
    awready_d   = 1'b0;
    wready_d    = 1'b0;
    bvalid_d    = bvalid_q && !bready;  // Hold response until taken
    arready_d   = 1'b0;
    rvalid_d    = rvalid_q && !(rready || (PIPE && !rvalid_pipe_q));

    // Skip the cycle of our own ready pulse, valids are still up then
    write_eligible = awvalid && wvalid && (!bvalid || bready) && !awready_q && !wready_q;
    read_eligible  = arvalid && (!rvalid || rready || (PIPE && !rvalid_pipe_q)) && !arready_q;

    if (write_eligible && (!read_eligible || last_read_q)) begin
      last_read_d = 1'b0;
      awready_d   = 1'b1;
      wready_d    = 1'b1;
      bvalid_d    = 1'b1;
      mem_wr      = 1'b1;
    end else if (read_eligible) begin
      last_read_d = 1'b1;
      arready_d   = 1'b1;
      rvalid_d    = 1'b1;
      mem_rd      = 1'b1;
    end
  end

  // Word addresses of both channels
  assign aw_word = WORD_ADDR_W'(word_index(32'(awaddr), LANE_BITS));
  assign ar_word = WORD_ADDR_W'(word_index(32'(araddr), LANE_BITS));

  assign mem.en_wr = mem_wr;
  assign mem.en_rd = mem_rd;
  assign mem.addr  = mem_rd ? ar_word : aw_word;
  assign mem.strb  = wstrb;
  assign mem.wdata = wdata;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clka) begin
    if (rsta) begin
      last_read_q   <= 1'b0;
      awready_q     <= 1'b0;
      wready_q      <= 1'b0;
      bvalid_q      <= 1'b0;
      arready_q     <= 1'b0;
      rvalid_q      <= 1'b0;
      rvalid_pipe_q <= 1'b0;
      rd_en_q       <= 1'b0;
    end else begin
      last_read_q <= last_read_d;
      awready_q   <= awready_d;
      wready_q    <= wready_d;
      bvalid_q    <= bvalid_d;
      arready_q   <= arready_d;
      rvalid_q    <= rvalid_d;
      rd_en_q     <= mem_rd;
      if (!rvalid_pipe_q || rready) begin
        rvalid_pipe_q <= rvalid_q;  // Output stage advances when free
      end
    end
  end

  // Read data capture and output stage
  always_ff @(posedge clka) begin
    if (rd_en_q) begin
      rdata_hold_q <= mem.rdata;  // Keep it through R back-pressure
    end
    if (!rvalid_pipe_q || rready) begin
      rdata_pipe_q <= rdata_core;
    end
  end

  assign rdata_core = rd_en_q ? mem.rdata : rdata_hold_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_bvalid_held : assert property (@(posedge clka) disable iff (rsta)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped without bready");

  a_rdata_stable : assert property (@(posedge clka) disable iff (rsta)
    rvalid && !rready |=> $stable(rdata))
    else $error("rdata changed while stalled");

endmodule

`default_nettype wire

/* hdl/mem_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One memory port of the shared storage
interface mem_port_if #(
  parameter int ADDR_W = axil_bram_pkg::AXIL_ADDR_W,
  parameter int DATA_W = axil_bram_pkg::AXIL_DATA_W,
  parameter int STRB_W = axil_bram_pkg::AXIL_DATA_W / 8
) ();

  logic              en_rd;   // Read strobe
  logic              en_wr;   // Write strobe
  logic [STRB_W-1:0] strb;    // Byte enables for writes
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] rdata;   // Valid the cycle after en_rd

  // Front end side
  modport ctrl (
    output en_rd, en_wr, strb, addr, wdata,
    input  rdata
  );

  // Storage side
  modport mem (
    input  en_rd, en_wr, strb, addr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

/* hdl/axil_bram_pkg.sv */
`default_nettype none

package axil_bram_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Default widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int AXIL_ADDR_W = 8;   // 256 bytes, 64 words
  localparam int AXIL_DATA_W = 32;  // Port A word
  localparam int BRAM_DATA_W = 8;   // Port B byte

  // AXI response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10              // Never issued by this bridge
  } axil_resp_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address split helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] word_index(input logic [31:0] byte_addr,
                                             input int unsigned lane_bits);
    return byte_addr >> lane_bits;  // Drop the lane bits
  endfunction

  function automatic logic [31:0] byte_lane(input logic [31:0] byte_addr,
                                            input int unsigned lane_bits);
    return byte_addr & ((32'd1 << lane_bits) - 32'd1);  // Keep the lane bits
  endfunction

endpackage

`default_nettype wire
